// ==== list.f ====
+incdir+.
exu_pkg.sv
idu.sv
alu.sv
exu.sv
lsu_mem.sv
exec_top.sv
tb_exec_top.sv

// ==== run.sh ====
#!/bin/bash
# builds and runs the execute cluster regression with verilator
verilator --binary --timing -f list.f --top-module tb_exec_top -o sim_exec \
  && ./obj_dir/sim_exec 2>&1 | tee /dev/stderr | grep -q "Regression passed" \
  || { echo "simulation did not pass"; exit 1; }

// ==== tb_exec_ref.svh ====
// reference model of the execute cluster plus memory mirror and lfsr source
`ifndef TB_EXEC_REF_SVH
`define TB_EXEC_REF_SVH

logic [31:0] lfsr_state = 32'h2da8_94cf;
logic [63:0] mirror [64];

// galois lfsr stepped once per bit taken
function automatic logic [31:0] rand_bits(int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v[i] = lfsr_state[0];
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
  end
  return v;
endfunction

function automatic logic [63:0] rand64();
  return {rand_bits(32), rand_bits(32)};
endfunction

function automatic logic [63:0] sext32(logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

function automatic logic [63:0] alu_model(logic [2:0] f3, logic alt, logic mext, logic word,
                                          logic [63:0] a, logic [63:0] b);
  logic signed [63:0] sa, sb, qs, rs;
  logic signed [31:0] wa, wb, wq, wr;
  logic [31:0] ua, ub;
  logic [63:0] r;
  sa = a;
  sb = b;
  wa = a[31:0];
  wb = b[31:0];
  ua = a[31:0];
  ub = b[31:0];
  qs = sa / sb;
  rs = sa % sb;
  wq = wa / wb;
  wr = wa % wb;
  r = '0;
  if (mext && !word) begin
    case (f3)
      3'd0: r = a * b;
      3'd4: if (b == 0) r = '1; else if (a == 64'h8000_0000_0000_0000 && b == '1) r = a; else r = qs;
      3'd5: if (b == 0) r = '1; else r = a / b;
      3'd6: if (b == 0) r = a; else if (a == 64'h8000_0000_0000_0000 && b == '1) r = 0; else r = rs;
      default: if (b == 0) r = a; else r = a % b;
    endcase
  end else if (mext) begin
    case (f3)
      3'd0: r = sext32(ua * ub);
      3'd4: if (ub == 0) r = '1; else if (ua == 32'h8000_0000 && ub == '1) r = sext32(ua);
            else r = sext32(wq);
      3'd5: if (ub == 0) r = '1; else r = sext32(ua / ub);
      3'd6: if (ub == 0) r = sext32(ua); else if (ua == 32'h8000_0000 && ub == '1) r = 0;
            else r = sext32(wr);
      default: if (ub == 0) r = sext32(ua); else r = sext32(ua % ub);
    endcase
  end else if (word) begin
    case (f3)
      3'd0: r = sext32(alt ? ua - ub : ua + ub);
      3'd1: r = sext32(ua << ub[4:0]);
      default: r = alt ? sext32(wa >>> ub[4:0]) : sext32(ua >> ub[4:0]);
    endcase
  end else begin
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[5:0];
      3'd2: r = {63'b0, sa < sb};
      3'd3: r = {63'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: if (alt) r = sa >>> b[5:0];
            else r = a >> b[5:0];
      3'd6: r = a | b;
      default: r = a & b;
    endcase
  end
  return r;
endfunction

function automatic exu_rsp_t ref_exec(exu_req_t rq);
  exu_rsp_t r;
  logic [6:0] opc;
  logic [2:0] f3;
  logic [63:0] imm_i, imm_s, imm_b, imm_u, imm_j, addr, ea, dw;
  logic take, isreg;
  opc = rq.instr[6:0];
  f3 = rq.instr[14:12];
  imm_i = {{52{rq.instr[31]}}, rq.instr[31:20]};
  imm_s = {{52{rq.instr[31]}}, rq.instr[31:25], rq.instr[11:7]};
  imm_b = {{52{rq.instr[31]}}, rq.instr[7], rq.instr[30:25], rq.instr[11:8], 1'b0};
  imm_u = {{32{rq.instr[31]}}, rq.instr[31:12], 12'b0};
  imm_j = {{44{rq.instr[31]}}, rq.instr[19:12], rq.instr[20], rq.instr[30:21], 1'b0};
  r = '0;
  r.rd = rq.instr[11:7];
  r.next_pc = rq.pc + 64'd4;
  isreg = (opc == OP_REG) || (opc == OP_REG32);
  case (opc)
    OP_LUI: r.busw = imm_u;
    OP_AUIPC: r.busw = rq.pc + imm_u;
    OP_JAL: begin
      r.busw = rq.pc + 64'd4;
      r.next_pc = rq.pc + imm_j;
    end
    OP_JALR: begin
      r.busw = rq.pc + 64'd4;
      r.next_pc = (rq.rs1 + imm_i) & ~64'd1;
    end
    OP_BRANCH: begin
      case (f3)
        3'd0: take = rq.rs1 == rq.rs2;
        3'd1: take = rq.rs1 != rq.rs2;
        3'd4: take = $signed(rq.rs1) < $signed(rq.rs2);
        3'd5: take = $signed(rq.rs1) >= $signed(rq.rs2);
        3'd6: take = rq.rs1 < rq.rs2;
        default: take = rq.rs1 >= rq.rs2;
      endcase
      if (take) r.next_pc = rq.pc + imm_b;
    end
    OP_LOAD: begin
      addr = rq.rs1 + imm_i;
      dw = mirror[addr[8:3]] >> {addr[2:0], 3'b000};
      case (f3)
        3'd0: r.busw = {{56{dw[7]}}, dw[7:0]};
        3'd1: r.busw = {{48{dw[15]}}, dw[15:0]};
        3'd2: r.busw = sext32(dw[31:0]);
        3'd4: r.busw = {56'b0, dw[7:0]};
        3'd5: r.busw = {48'b0, dw[15:0]};
        3'd6: r.busw = {32'b0, dw[31:0]};
        default: r.busw = dw;
      endcase
    end
    OP_STORE: begin
      addr = rq.rs1 + imm_s;
      for (int i = 0; i < (1 << f3[1:0]); i++) begin
        ea = addr + 64'(i);
        mirror[ea[8:3]][8*ea[2:0] +: 8] = rq.rs2[8*i +: 8];
      end
    end
    OP_IMM, OP_IMM32, OP_REG, OP_REG32: begin
      r.busw = alu_model(f3, (f3 == 3'd0) ? (isreg && rq.instr[30]) : rq.instr[30],
                         isreg && rq.instr[25], opc[3], rq.rs1, isreg ? rq.rs2 : imm_i);
    end
    default: begin
      if (rq.instr == 32'h0010_0073) r.ebreak = 1'b1;
      else r.illegal = 1'b1;
    end
  endcase
  r.rd_wen = !(r.illegal || r.ebreak || opc == OP_BRANCH || opc == OP_STORE);
  return r;
endfunction

`endif

// ==== tb_exec_top.sv ====
// testbench for the execute cluster with random back-pressure
module tb_exec_top
  import exu_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_REQ = 15 * 8 + 8 + 9 * 6 + 26 + 64 + 80 + 2;
  localparam int WATCHDOG_CYCLES = 16 + 40 * N_REQ;

  logic     clk, i_rst, i_req_valid, o_req_ready, o_rsp_valid, i_rsp_ready, ready_next;
  exu_req_t i_req;
  exu_rsp_t o_rsp, held_rsp;
  exu_rsp_t exp_q [$];
  int       consumed, error_count;
  logic     acc_prev, stalled_prev;

  `include "tb_exec_ref.svh"

  exec_top uut (
    .i_clk       (clk),
    .i_rst       (i_rst),
    .i_req_valid (i_req_valid),
    .i_req       (i_req),
    .o_req_ready (o_req_ready),
    .o_rsp_valid (o_rsp_valid),
    .o_rsp       (o_rsp),
    .i_rsp_ready (i_rsp_ready)
  );

  always #10 clk = ~clk;

  task automatic fail_run(string why);
    error_count++;
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_val(string name, logic [255:0] got, logic [255:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp));
    end
  endtask

  // source register fields fixed since operands come with the request
  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, 5'(rand_bits(5)), opc};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [2:0] f3, logic [6:0] opc);
    return {imm, 5'd1, f3, 5'(rand_bits(5)), opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [2:0] f3);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] off, logic [2:0] f3);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'(rand_bits(5)), OP_JAL};
  endfunction

  function automatic logic [9:0] rr_code(int k);
    logic [9:0] c [15];
    c = '{{7'h00, 3'd0}, {7'h20, 3'd0}, {7'h00, 3'd1}, {7'h00, 3'd2}, {7'h00, 3'd3},
          {7'h00, 3'd4}, {7'h00, 3'd5}, {7'h20, 3'd5}, {7'h00, 3'd6}, {7'h00, 3'd7},
          {7'h01, 3'd0}, {7'h01, 3'd4}, {7'h01, 3'd5}, {7'h01, 3'd6}, {7'h01, 3'd7}};
    return c[k];
  endfunction

  task automatic issue(logic [31:0] instr, logic [63:0] pc, logic [63:0] rs1, logic [63:0] rs2);
    exu_req_t rq;
    rq = '{instr: instr, pc: pc, rs1: rs1, rs2: rs2};
    #1;
    i_req_valid = 1'b1;
    i_req = rq;
    do @(posedge clk); while (!o_req_ready);
    exp_q.push_back(ref_exec(rq));
  endtask

  function automatic logic [63:0] rand_pc();
    return rand64() & ~64'd3;
  endfunction

  // response ready low about a third of the time
  always @(negedge clk) ready_next = (8'(rand_bits(8)) >= 8'd85);
  always @(posedge clk) begin
    #1;
    i_rsp_ready = ready_next;
  end

  always @(posedge clk) begin
    exu_rsp_t e;
    if (!i_rst) begin
      if (acc_prev && !o_rsp_valid) fail_run("no response one cycle after acceptance");
      if (stalled_prev) begin
        check_val("o_rsp_valid", 256'(o_rsp_valid), 256'(1));
        check_val("held o_rsp", 256'(o_rsp), 256'(held_rsp));
      end
      if (o_rsp_valid && !i_rsp_ready) check_val("o_req_ready", 256'(o_req_ready), 256'(0));
      if (o_rsp_valid && i_rsp_ready) begin
        if (exp_q.size() == 0) fail_run("response arrived without a pending request");
        e = exp_q.pop_front();
        if (e.rd_wen) check_val("busw", 256'(o_rsp.busw), 256'(e.busw));
        check_val("next_pc", 256'(o_rsp.next_pc), 256'(e.next_pc));
        check_val("rd", 256'(o_rsp.rd), 256'(e.rd));
        check_val("rd_wen", 256'(o_rsp.rd_wen), 256'(e.rd_wen));
        check_val("illegal", 256'(o_rsp.illegal), 256'(e.illegal));
        check_val("ebreak", 256'(o_rsp.ebreak), 256'(e.ebreak));
        consumed++;
      end
      stalled_prev = o_rsp_valid && !i_rsp_ready;
      held_rsp = o_rsp;
      acc_prev = i_req_valid && o_req_ready;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 20);
    $display("watchdog expired: responses stopped arriving");
    $display("Regression failed");
    $fatal(1);
  end

  initial begin
    logic [9:0]  code;
    logic [63:0] a, b, addr;
    logic [2:0]  f3, off;
    logic [1:0]  sz;
    logic [11:0] imm;
    clk = 1'b0;
    i_rst = 1'b1;
    i_req_valid = 1'b0;
    i_req = '0;
    i_rsp_ready = 1'b0;
    consumed = 0;
    error_count = 0;
    acc_prev = 1'b0;
    stalled_prev = 1'b0;
    repeat (16) @(posedge clk);
    #1 i_rst = 1'b0;
    @(posedge clk);
    for (int k = 0; k < 15; k++) begin
      code = rr_code(k);
      for (int n = 0; n < 8; n++) begin
        issue(enc_r(code[9:3], code[2:0], OP_REG), rand_pc(), rand64(), rand64());
      end
    end
    // divide by zero and overflow corners
    for (int k = 4; k < 8; k++) begin
      issue(enc_r(7'h01, 3'(k), OP_REG), rand_pc(), rand64(), 64'd0);
      issue(enc_r(7'h01, 3'(k), OP_REG), rand_pc(), 64'h8000_0000_0000_0000, '1);
    end
    for (int n = 0; n < 6; n++) begin
      issue(enc_i(12'(rand_bits(12)), 3'd0, OP_IMM), rand_pc(), rand64(), rand64());
      issue(enc_i({6'b0, 6'(rand_bits(6))}, 3'd1, OP_IMM), rand_pc(), rand64(), rand64());
      issue(enc_i({6'b010000, 6'(rand_bits(6))}, 3'd5, OP_IMM), rand_pc(), rand64(), rand64());
      issue(enc_i(12'(rand_bits(12)), 3'd0, OP_IMM32), rand_pc(), rand64(), rand64());
      issue(enc_i({7'b0100000, 5'(rand_bits(5))}, 3'd5, OP_IMM32), rand_pc(), rand64(),
            rand64());
      issue(enc_r(7'h01, 3'd4, OP_REG32), rand_pc(), rand64(), rand64());
      issue(enc_r(7'h01, 3'd7, OP_REG32), rand_pc(), rand64(), rand64());
      issue({20'(rand_bits(20)), 5'(rand_bits(5)), OP_LUI}, rand_pc(), rand64(), rand64());
      issue({20'(rand_bits(20)), 5'(rand_bits(5)), OP_AUIPC}, rand_pc(), rand64(), rand64());
    end
    for (int k = 0; k < 6; k++) begin
      f3 = (k < 2) ? 3'(k) : 3'(k + 2);
      a = rand64();
      b = rand64();
      issue(enc_b({12'(rand_bits(12)), 1'b0}, f3), rand_pc(), a, a);
      issue(enc_b({12'(rand_bits(12)), 1'b0}, f3), rand_pc(), a, b);
      issue(enc_b({12'(rand_bits(12)), 1'b0}, f3), rand_pc(), b, a);
    end
    for (int n = 0; n < 4; n++) begin
      issue(enc_j({20'(rand_bits(20)), 1'b0}), rand_pc(), rand64(), rand64());
      issue(enc_i(12'(rand_bits(12)), 3'd0, OP_JALR), rand_pc(), rand64(), rand64());
    end
    // fill every doubleword so later loads see defined data
    for (int k = 0; k < 64; k++) begin
      addr = 64'(k * 8);
      issue(enc_s(12'd0, 3'd3), rand_pc(), addr, {addr[31:0] ^ 32'ha5a5_0000, ~addr[31:0]});
    end
    for (int n = 0; n < 40; n++) begin
      sz = 2'(rand_bits(2));
      off = 3'(rand_bits(3));
      off = (off >> sz) << sz;
      addr = {55'b0, 6'(rand_bits(6)), off};
      imm = {7'b0, 5'(rand_bits(5))};
      issue(enc_s(imm, {1'b0, sz}), rand_pc(), addr - 64'(imm), rand64());
      f3 = 3'(rand_bits(3));
      if (f3 == 3'd7) f3 = 3'd3;
      off = 3'(rand_bits(3));
      off = (off >> f3[1:0]) << f3[1:0];
      if (rand_bits(1) == 0) addr = {55'b0, 6'(rand_bits(6)), off};
      else addr = {addr[63:3], off};
      issue(enc_i(imm, f3, OP_LOAD), rand_pc(), addr - 64'(imm), rand64());
    end
    issue({25'(rand_bits(25)), 7'b0001011}, rand_pc(), rand64(), rand64());
    issue(INSTR_EBREAK, rand_pc(), rand64(), rand64());
    #1 i_req_valid = 1'b0;
    wait (consumed == N_REQ);
    repeat (3) @(posedge clk);
    if (error_count == 0 && exp_q.size() == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Regression failed");
      $fatal(1);
    end
  end

endmodule

// ==== exec_top.sv ====
// rv64im execute cluster with valid/ready request and response streams
module exec_top
  import exu_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_req_valid,
  input  exu_req_t i_req,
  output logic     o_req_ready,
  output logic     o_rsp_valid,
  output exu_rsp_t o_rsp,
  input  logic     i_rsp_ready
);

  ctrl_t       ctrl;
  logic [63:0] imm;
  logic [4:0]  rd;
  logic [63:0] alu_result, next_pc, addr, wdata, rdata;
  logic [7:0]  wstrb;
  logic        accept;

  // output stage
  logic        out_valid;
  ctrl_t       ctrl_q;
  logic [63:0] alu_q, next_pc_q;
  logic [4:0]  rd_q;
  logic [2:0]  off_q;
  logic [63:0] load_raw, load_data;

  idu u_idu (
    .i_instr (i_req.instr),
    .o_ctrl  (ctrl),
    .o_imm   (imm),
    .o_rd    (rd)
  );

  exu u_exu (
    .i_req        (i_req),
    .i_ctrl       (ctrl),
    .i_imm        (imm),
    .o_alu_result (alu_result),
    .o_next_pc    (next_pc),
    .o_addr       (addr),
    .o_wdata      (wdata),
    .o_wstrb      (wstrb)
  );

  lsu_mem u_lsu_mem (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_en    (accept),
    .i_we    (accept && ctrl.mem_write),
    .i_addr  (addr[MEM_AW+2:3]),
    .i_wdata (wdata),
    .i_wstrb (wstrb),
    .o_rdata (rdata)
  );

  assign o_req_ready = !out_valid || i_rsp_ready;
  assign accept = i_req_valid && o_req_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      out_valid <= 1'b0;
    end else if (o_req_ready) begin
      out_valid <= i_req_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      ctrl_q <= ctrl;
      alu_q <= alu_result;
      next_pc_q <= next_pc;
      rd_q <= rd;
      off_q <= addr[2:0];
    end
  end

  // load extraction from the registered doubleword
  assign load_raw = rdata >> {off_q, 3'b000};

  always_comb begin
    case (ctrl_q.mem_op)
      MEM_LB: load_data = {{56{load_raw[7]}}, load_raw[7:0]};
      MEM_LBU: load_data = {56'b0, load_raw[7:0]};
      MEM_LH: load_data = {{48{load_raw[15]}}, load_raw[15:0]};
      MEM_LHU: load_data = {48'b0, load_raw[15:0]};
      MEM_LW: load_data = {{32{load_raw[31]}}, load_raw[31:0]};
      MEM_LWU: load_data = {32'b0, load_raw[31:0]};
      default: load_data = load_raw;
    endcase
  end

  always_comb begin
    o_rsp.busw = ctrl_q.mem_read ? load_data : alu_q;
    o_rsp.next_pc = next_pc_q;
    o_rsp.rd = rd_q;
    o_rsp.rd_wen = ctrl_q.rd_wen;
    o_rsp.illegal = ctrl_q.illegal;
    o_rsp.ebreak = ctrl_q.ebreak;
  end

  assign o_rsp_valid = out_valid;

  // stalled response holds, including the memory read register behind busw
  assert property (@(posedge i_clk) disable iff (i_rst)
                   o_rsp_valid && !i_rsp_ready |=> o_rsp_valid && $stable(o_rsp))
    else $error("response changed under back-pressure");

endmodule

// ==== lsu_mem.sv ====
// local data memory with byte lane writes and registered read
module lsu_mem
  import exu_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_en,
  input  logic              i_we,
  input  logic [MEM_AW-1:0] i_addr,
  input  logic [63:0]       i_wdata,
  input  logic [7:0]        i_wstrb,
  output logic [63:0]       o_rdata
);

  logic [63:0] mem [MEM_WORDS];

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      if (i_we) begin
        for (int b = 0; b < 8; b++) begin
          if (i_wstrb[b]) begin
            mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
          end
        end
      end
      // read register holds while disabled
      o_rdata <= mem[i_addr];
    end
  end

  // writes only come from accepted requests
  assert property (@(posedge i_clk) disable iff (i_rst) i_we |-> i_en)
    else $error("memory write without enable");

endmodule

// ==== exu.sv ====
// execute unit with alu, branch resolution, next pc and store lane alignment
module exu
  import exu_pkg::*;
(
  input  exu_req_t    i_req,
  input  ctrl_t       i_ctrl,
  input  logic [63:0] i_imm,
  output logic [63:0] o_alu_result,
  output logic [63:0] o_next_pc,
  output logic [63:0] o_addr,
  output logic [63:0] o_wdata,
  output logic [7:0]  o_wstrb
);

  logic       equal, less, taken;
  logic [7:0] lane_mask;
  logic [2:0] align_mask;

  alu u_alu (
    .i_ctrl   (i_ctrl),
    .i_rs1    (i_req.rs1),
    .i_rs2    (i_req.rs2),
    .i_imm    (i_imm),
    .i_pc     (i_req.pc),
    .o_result (o_alu_result)
  );

  assign equal = (i_req.rs1 == i_req.rs2);
  assign less = i_ctrl.br_unsigned ? (i_req.rs1 < i_req.rs2)
                                   : ($signed(i_req.rs1) < $signed(i_req.rs2));

  always_comb begin
    case (i_ctrl.branch)
      BR_JAL, BR_JALR: taken = 1'b1;
      BR_BEQ: taken = equal;
      BR_BNE: taken = !equal;
      BR_BLT: taken = less;
      BR_BGE: taken = !less;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (i_ctrl.branch == BR_JALR) begin
      o_next_pc = (i_req.rs1 + i_imm) & ~64'd1;
    end else begin
      o_next_pc = i_req.pc + (taken ? i_imm : 64'd4);
    end
  end

  assign o_addr = o_alu_result;

  // replicate the store value so every aligned lane already holds it
  always_comb begin
    case (i_ctrl.store_size)
      2'd0: begin
        lane_mask = 8'h01;
        align_mask = 3'b000;
        o_wdata = {8{i_req.rs2[7:0]}};
      end
      2'd1: begin
        lane_mask = 8'h03;
        align_mask = 3'b001;
        o_wdata = {4{i_req.rs2[15:0]}};
      end
      2'd2: begin
        lane_mask = 8'h0f;
        align_mask = 3'b011;
        o_wdata = {2{i_req.rs2[31:0]}};
      end
      default: begin
        lane_mask = 8'hff;
        align_mask = 3'b111;
        o_wdata = i_req.rs2;
      end
    endcase
  end

  assign o_wstrb = i_ctrl.mem_write ? (lane_mask << o_addr[2:0]) : 8'h00;

  // stimulus and decoder together never produce a misaligned store
  always_comb begin
    if (i_ctrl.mem_write && !$isunknown(o_addr)) begin
      assert final ((o_addr[2:0] & align_mask) == 3'b000)
        else $error("misaligned store address %h", o_addr);
    end
  end

endmodule

// ==== alu.sv ====
// integer and multiply/divide alu with rv64 word forms
module alu
  import exu_pkg::*;
(
  input  ctrl_t       i_ctrl,
  input  logic [63:0] i_rs1,
  input  logic [63:0] i_rs2,
  input  logic [63:0] i_imm,
  input  logic [64-1:0] i_pc,
  output logic [63:0] o_result
);

  logic [63:0] src_a, src_b;
  logic [63:0] a_sx, a_zx, b_sx, b_zx;
  logic [5:0]  shamt;
  logic [63:0] mul_res, sra_res;
  logic [63:0] quot_s, rem_s, quot_u, rem_u;
  logic        lt_s, lt_u;
  logic        div_zero, div_ovf;
  logic [63:0] res;

  assign src_a = i_ctrl.alu_a_pc ? i_pc : i_rs1;

  always_comb begin
    case (i_ctrl.alu_b_sel)
      B_IMM: src_b = i_imm;
      B_FOUR: src_b = 64'd4;
      default: src_b = i_rs2;
    endcase
  end

  // word forms see 32-bit operands, extended to suit the operation
  assign a_sx = i_ctrl.word_cut ? {{32{src_a[31]}}, src_a[31:0]} : src_a;
  assign a_zx = i_ctrl.word_cut ? {32'b0, src_a[31:0]} : src_a;
  assign b_sx = i_ctrl.word_cut ? {{32{src_b[31]}}, src_b[31:0]} : src_b;
  assign b_zx = i_ctrl.word_cut ? {32'b0, src_b[31:0]} : src_b;
  assign shamt = i_ctrl.word_cut ? {1'b0, src_b[4:0]} : src_b[5:0];

  assign mul_res = $signed(a_sx) * $signed(b_sx);
  assign sra_res = $signed(a_sx) >>> shamt;
  assign lt_s = $signed(a_sx) < $signed(b_sx);
  assign lt_u = a_zx < b_zx;

  assign div_zero = (b_zx == 64'b0);
  assign div_ovf = (a_sx == {1'b1, 63'b0}) && (b_sx == {64{1'b1}});
  assign quot_s = $signed(a_sx) / $signed(b_sx);
  assign rem_s = $signed(a_sx) % $signed(b_sx);
  assign quot_u = a_zx / b_zx;
  assign rem_u = a_zx % b_zx;

  always_comb begin
    case (i_ctrl.alu_op)
      ALU_COPY: res = i_imm;
      ALU_ADD: res = a_zx + b_zx;
      ALU_SUB: res = a_zx - b_zx;
      ALU_SLT: res = {63'b0, lt_s};
      ALU_SLTU: res = {63'b0, lt_u};
      ALU_XOR: res = a_zx ^ b_zx;
      ALU_AND: res = a_zx & b_zx;
      ALU_OR: res = a_zx | b_zx;
      ALU_SLL: res = a_zx << shamt;
      ALU_SRL: res = a_zx >> shamt;
      ALU_SRA: res = sra_res;
      ALU_MUL: res = mul_res;
      ALU_DIV: res = div_zero ? {64{1'b1}} : (div_ovf ? a_sx : quot_s);
      ALU_DIVU: res = div_zero ? {64{1'b1}} : quot_u;
      ALU_REM: res = div_zero ? a_sx : (div_ovf ? 64'b0 : rem_s);
      ALU_REMU: res = div_zero ? a_zx : rem_u;
      default: res = 64'b0;
    endcase
  end

  assign o_result = i_ctrl.word_cut ? {{32{res[31]}}, res[31:0]} : res;

  // decoder must only ever hand over one of the sixteen operations
  always_comb begin
    if (!$isunknown(i_ctrl.alu_op)) begin
      assert final (i_ctrl.alu_op inside {ALU_COPY, ALU_ADD, ALU_SLT, ALU_SLTU, ALU_SUB,
                                          ALU_XOR, ALU_AND, ALU_OR, ALU_SLL, ALU_SRL,
                                          ALU_SRA, ALU_MUL, ALU_DIV, ALU_DIVU, ALU_REM,
                                          ALU_REMU})
        else $error("undefined alu operation %b", i_ctrl.alu_op);
    end
  end

endmodule

// ==== idu.sv ====
// instruction decoder producing control signals and immediate for rv64im
module idu
  import exu_pkg::*;
(
  input  logic [31:0] i_instr,
  output ctrl_t       o_ctrl,
  output logic [63:0] o_imm,
  output logic [4:0]  o_rd
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [63:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opcode = i_instr[6:0];
  assign funct3 = i_instr[14:12];
  assign funct7 = i_instr[31:25];
  assign o_rd = i_instr[11:7];

  assign imm_i = {{52{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{52{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{51{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_u = {{32{i_instr[31]}}, i_instr[31:12], 12'b0};
  assign imm_j = {{43{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};

  always_comb begin
    o_ctrl = '0;
    o_ctrl.alu_op = ALU_ADD;
    o_ctrl.branch = BR_NONE;
    o_imm = imm_i;
    case (opcode)
      OP_LUI: begin
        o_ctrl.alu_op = ALU_COPY;
        o_ctrl.rd_wen = 1'b1;
        o_imm = imm_u;
      end
      OP_AUIPC: begin
        o_ctrl.alu_a_pc = 1'b1;
        o_ctrl.alu_b_sel = B_IMM;
        o_ctrl.rd_wen = 1'b1;
        o_imm = imm_u;
      end
      OP_JAL, OP_JALR: begin
        // link value is pc + 4
        o_ctrl.alu_a_pc = 1'b1;
        o_ctrl.alu_b_sel = B_FOUR;
        o_ctrl.rd_wen = 1'b1;
        o_ctrl.branch = (opcode == OP_JAL) ? BR_JAL : BR_JALR;
        o_ctrl.illegal = (opcode == OP_JALR) && (funct3 != 3'b000);
        o_imm = (opcode == OP_JAL) ? imm_j : imm_i;
      end
      OP_BRANCH: begin
        o_imm = imm_b;
        o_ctrl.br_unsigned = funct3[1];
        case (funct3)
          3'b000: o_ctrl.branch = BR_BEQ;
          3'b001: o_ctrl.branch = BR_BNE;
          3'b100, 3'b110: o_ctrl.branch = BR_BLT;
          3'b101, 3'b111: o_ctrl.branch = BR_BGE;
          default: o_ctrl.illegal = 1'b1;
        endcase
      end
      OP_LOAD: begin
        o_ctrl.alu_b_sel = B_IMM;
        o_ctrl.mem_read = 1'b1;
        o_ctrl.rd_wen = 1'b1;
        case (funct3)
          3'b000: o_ctrl.mem_op = MEM_LB;
          3'b001: o_ctrl.mem_op = MEM_LH;
          3'b010: o_ctrl.mem_op = MEM_LW;
          3'b011: o_ctrl.mem_op = MEM_LD;
          3'b100: o_ctrl.mem_op = MEM_LBU;
          3'b101: o_ctrl.mem_op = MEM_LHU;
          3'b110: o_ctrl.mem_op = MEM_LWU;
          default: o_ctrl.illegal = 1'b1;
        endcase
      end
      OP_STORE: begin
        o_ctrl.alu_b_sel = B_IMM;
        o_ctrl.mem_write = 1'b1;
        o_ctrl.store_size = funct3[1:0];
        o_ctrl.illegal = funct3[2];
        o_imm = imm_s;
      end
      OP_IMM, OP_IMM32: begin
        o_ctrl.alu_b_sel = B_IMM;
        o_ctrl.rd_wen = 1'b1;
        o_ctrl.word_cut = (opcode == OP_IMM32);
        case (funct3)
          3'b000: o_ctrl.alu_op = ALU_ADD;
          3'b001: begin
            o_ctrl.alu_op = ALU_SLL;
            o_ctrl.illegal = o_ctrl.word_cut ? (funct7 != 7'b0) : (i_instr[31:26] != 6'b0);
          end
          3'b101: begin
            // bit 30 picks arithmetic shift
            o_ctrl.alu_op = i_instr[30] ? ALU_SRA : ALU_SRL;
            o_ctrl.illegal = o_ctrl.word_cut ? ({funct7[6], funct7[4:0]} != 6'b0)
                                             : ({i_instr[31], i_instr[29:26]} != 5'b0);
          end
          3'b010: o_ctrl.alu_op = ALU_SLT;
          3'b011: o_ctrl.alu_op = ALU_SLTU;
          3'b100: o_ctrl.alu_op = ALU_XOR;
          3'b110: o_ctrl.alu_op = ALU_OR;
          default: o_ctrl.alu_op = ALU_AND;
        endcase
        if (o_ctrl.word_cut && funct3 != 3'b000 && funct3 != 3'b001 && funct3 != 3'b101) begin
          o_ctrl.illegal = 1'b1;
        end
      end
      OP_REG, OP_REG32: begin
        o_ctrl.rd_wen = 1'b1;
        o_ctrl.word_cut = (opcode == OP_REG32);
        case ({funct7, funct3})
          10'b0000000_000: o_ctrl.alu_op = ALU_ADD;
          10'b0000000_001: o_ctrl.alu_op = ALU_SLL;
          10'b0000000_101: o_ctrl.alu_op = ALU_SRL;
          10'b0100000_000: o_ctrl.alu_op = ALU_SUB;
          10'b0100000_101: o_ctrl.alu_op = ALU_SRA;
          10'b0000001_000: o_ctrl.alu_op = ALU_MUL;
          10'b0000001_100: o_ctrl.alu_op = ALU_DIV;
          10'b0000001_101: o_ctrl.alu_op = ALU_DIVU;
          10'b0000001_110: o_ctrl.alu_op = ALU_REM;
          10'b0000001_111: o_ctrl.alu_op = ALU_REMU;
          10'b0000000_010: o_ctrl.alu_op = ALU_SLT;
          10'b0000000_011: o_ctrl.alu_op = ALU_SLTU;
          10'b0000000_100: o_ctrl.alu_op = ALU_XOR;
          10'b0000000_110: o_ctrl.alu_op = ALU_OR;
          10'b0000000_111: o_ctrl.alu_op = ALU_AND;
          default: o_ctrl.illegal = 1'b1;
        endcase
        // no word forms of slt or logic ops
        if (o_ctrl.word_cut && (funct3 == 3'b010 || funct3 == 3'b011 ||
            (funct7 == 7'b0 && (funct3 == 3'b100 || funct3 == 3'b110 || funct3 == 3'b111)))) begin
          o_ctrl.illegal = 1'b1;
        end
      end
      OP_SYSTEM: begin
        o_ctrl.ebreak = (i_instr == INSTR_EBREAK);
        o_ctrl.illegal = (i_instr != INSTR_EBREAK);
      end
      default: o_ctrl.illegal = 1'b1;
    endcase
    // illegal encodings have no side effects
    if (o_ctrl.illegal) begin
      o_ctrl.rd_wen = 1'b0;
      o_ctrl.mem_read = 1'b0;
      o_ctrl.mem_write = 1'b0;
      o_ctrl.branch = BR_NONE;
    end
  end

endmodule

// ==== exu_pkg.sv ====
// exec cluster shared encodings, control and stream payload types
package exu_pkg;

  localparam int MEM_WORDS = 64;
  localparam int MEM_AW = 6;

  // rv64 major opcodes
  localparam logic [6:0] OP_LUI = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_JAL = 7'b1101111;
  localparam logic [6:0] OP_JALR = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_IMM32 = 7'b0011011;
  localparam logic [6:0] OP_REG = 7'b0110011;
  localparam logic [6:0] OP_REG32 = 7'b0111011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

  // operand b sources
  localparam logic [1:0] B_RS2 = 2'd0;
  localparam logic [1:0] B_IMM = 2'd1;
  localparam logic [1:0] B_FOUR = 2'd2;

  typedef enum logic [4:0] {
    ALU_ADD  = 5'b00000,
    ALU_SLL  = 5'b00001,
    ALU_SLT  = 5'b00010,
    ALU_COPY = 5'b00011,
    ALU_XOR  = 5'b00100,
    ALU_SRL  = 5'b00101,
    ALU_OR   = 5'b00110,
    ALU_AND  = 5'b00111,
    ALU_SUB  = 5'b01000,
    ALU_SLTU = 5'b01010,
    ALU_SRA  = 5'b01101,
    ALU_REMU = 5'b11001,
    ALU_DIVU = 5'b11010,
    ALU_DIV  = 5'b11011,
    ALU_MUL  = 5'b11100,
    ALU_REM  = 5'b11101
  } alu_op_e;

  // bltu and bgeu travel as blt and bge plus br_unsigned
  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_BEQ  = 3'b100,
    BR_BNE  = 3'b101,
    BR_BLT  = 3'b110,
    BR_BGE  = 3'b111
  } branch_e;

  typedef enum logic [2:0] {
    MEM_LB  = 3'b000,
    MEM_LBU = 3'b001,
    MEM_LH  = 3'b010,
    MEM_LHU = 3'b011,
    MEM_LW  = 3'b100,
    MEM_LWU = 3'b101,
    MEM_LD  = 3'b110
  } mem_op_e;

  typedef struct packed {
    logic       alu_a_pc;
    logic [1:0] alu_b_sel;
    alu_op_e    alu_op;
    logic       word_cut;
    branch_e    branch;
    logic       br_unsigned;
    mem_op_e    mem_op;
    logic       mem_read;
    logic       mem_write;
    logic [1:0] store_size;
    logic       rd_wen;
    logic       illegal;
    logic       ebreak;
  } ctrl_t;

  typedef struct packed {
    logic [31:0] instr;
    logic [63:0] pc;
    logic [63:0] rs1;
    logic [63:0] rs2;
  } exu_req_t;

  typedef struct packed {
    logic [63:0] busw;
    logic [63:0] next_pc;
    logic [4:0]  rd;
    logic        rd_wen;
    logic        illegal;
    logic        ebreak;
  } exu_rsp_t;

endpackage
